// ==== design/mem_map_pkg.sv ====
// Memory map of the graphics ROM side of the SDRAM bank.
// Region offsets count 16-bit bank words; header positions index the
// configuration bytes at the start of a ROM download.
package mem_map_pkg;

    // Consumer address widths, one item per address
    localparam int MAP_AW  = 15; // Tile map, one word per item
    localparam int CHAR_AW = 13; // Characters, two words per item
    localparam int SCR_AW  = 17; // Scroll tiles, two words per item

    // Region bases in bank words
    localparam logic [21:0] MAP_OFFSET  = 22'h00_0000; // 32k words
    localparam logic [21:0] CHAR_OFFSET = 22'h00_8000; // 16k words
    localparam logic [21:0] SCR_OFFSET  = 22'h01_0000; // 256k words

    // Header byte positions
    localparam logic [4:0] HDR_DEC     = 5'h10; // Decoder type
    localparam logic [4:0] HDR_MCU     = 5'h13; // MCU present in bit 0
    localparam logic [4:0] HDR_GAME_ID = 5'h18;

endpackage

// ==== design/sdram_bank_pkg.sv ====
// SDRAM bank protocol definitions shared by the slots, the arbiter
// and the burst counter.
package sdram_bank_pkg;

    localparam int SDRAM_DW  = 16; // Data word width
    localparam int BURST_LEN = 2;  // Words returned per bank read
    localparam int BANK_AW   = 22; // Word address width

    typedef logic [BANK_AW-1:0]  bank_addr_t;
    typedef logic [SDRAM_DW-1:0] sdram_word_t;

endpackage

// ==== design/game_header.sv ====
// Captures the game configuration bytes from the ROM download header.
// Bytes arrive one per cycle on header_wr; outputs hold until rewritten.
module game_header (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       header_wr,
    input  logic [4:0] header_addr,
    input  logic [7:0] header_data,
    output logic [7:0] game_id,
    output logic       dec_type,
    output logic       dec_en,
    output logic       mcu_en
);
    import mem_map_pkg::*;

    logic dec_flag; // Any decoder selected in the header

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            game_id  <= '0;
            dec_type <= 1'b0;
            dec_flag <= 1'b0;
            mcu_en   <= 1'b0;
            dec_en   <= 1'b0;
        end else begin
            if (header_wr) begin
                if (header_addr == HDR_DEC) begin
                    dec_flag <= |header_data[1:0];
                    dec_type <= header_data[1];
                end
                if (header_addr == HDR_MCU)     mcu_en  <= header_data[0];
                if (header_addr == HDR_GAME_ID) game_id <= header_data;
            end
            dec_en <= dec_flag; // One extra stage before the decoder sees it
        end
    end

endmodule

// ==== design/rom_slot_cache.sv ====
// One consumer slot of the bank. Holds the last fetched item so that a
// repeated address answers in one cycle; flags a miss to the arbiter and
// assembles the burst words into the payload type.
module rom_slot_cache #(
    parameter int  AW     = 8,
    parameter type data_t = logic [15:0]
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        cs,
    input  logic [AW-1:0]               addr,
    output data_t                       data,
    output logic                        ok,
    output logic                        miss,
    input  sdram_bank_pkg::sdram_word_t fill_word,
    input  logic                        fill_idx,
    input  logic                        fill_en,
    input  logic                        fill_done
);
    import sdram_bank_pkg::*;

    localparam int DW    = $bits(data_t);
    localparam int WORDS = DW / SDRAM_DW; // Bank words per item

    logic [AW-1:0] tag;
    logic          valid;
    logic [DW-1:0] payload;
    logic          hit;

    assign hit  = valid && (tag == addr);
    assign miss = cs && !hit;
    assign data = data_t'(payload);

    // Second word lands high, first word low
    always_ff @(posedge clk) begin
        for (int w = 0; w < WORDS; w++) begin
            if (fill_en && (int'(fill_idx) == w)) begin
                payload[w*SDRAM_DW +: SDRAM_DW] <= fill_word;
            end
        end
        if (fill_done) tag <= addr; // Consumer holds addr through the fill
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
            ok    <= 1'b0;
        end else begin
            if (fill_done) valid <= 1'b1;
            ok <= cs && (hit || fill_done); // Rises right after the last word
        end
    end

    // Data only flows into a slot that is waiting for it
    a_fill_on_miss: assert property (
        @(posedge clk) disable iff (!arst_n) fill_en |-> miss
    );

endmodule

// ==== design/slot_arbiter.sv ====
// Round-robin arbiter in front of the SDRAM bank. Picks the next slot
// that misses, holds the read request until ack and keeps the grant
// until the burst has been delivered.
module slot_arbiter #(
    parameter int N_SLOTS = 3
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [N_SLOTS-1:0]         miss,
    input  sdram_bank_pkg::bank_addr_t slot_addr [N_SLOTS],
    output logic                       sdram_req,
    output sdram_bank_pkg::bank_addr_t sdram_addr,
    input  logic                       sdram_ack,
    input  logic                       data_rdy,
    output logic [N_SLOTS-1:0]         grant
);
    import sdram_bank_pkg::*;

    localparam int IW = (N_SLOTS > 1) ? $clog2(N_SLOTS) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } state_t;

    state_t        state;
    logic [IW-1:0] last_q;     // Slot served most recently
    logic [IW-1:0] pick;
    logic          pick_valid;
    bank_addr_t    addr_q;

    assign sdram_addr = addr_q;

    // Search starts just after the last served slot
    always_comb begin
        int idx;
        pick_valid = 1'b0;
        pick       = last_q;
        for (int k = 1; k <= N_SLOTS; k++) begin
            idx = (int'(last_q) + k) % N_SLOTS;
            if (!pick_valid && miss[idx]) begin
                pick_valid = 1'b1;
                pick       = IW'(idx);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            grant     <= '0;
            sdram_req <= 1'b0;
            last_q    <= IW'(N_SLOTS - 1); // Slot 0 goes first
        end else begin
            case (state)
                ST_IDLE: begin
                    if (pick_valid) begin
                        grant     <= N_SLOTS'(1) << pick;
                        last_q    <= pick;
                        sdram_req <= 1'b1;
                        state     <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (data_rdy) begin // Burst done, free the bank
                        grant <= '0;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && pick_valid) addr_q <= slot_addr[pick];
    end

    a_req_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr)
    );

    a_grant_onehot: assert property (
        @(posedge clk) disable iff (!arst_n) $onehot0(grant)
    );

endmodule

// ==== design/burst_counter.sv ====
// Counts the data words of a bank burst from data_dst to data_rdy and
// gives the index of the word on data_read with a fill strobe.
module burst_counter (
    input  logic clk,
    input  logic arst_n,
    input  logic data_dst,
    input  logic data_rdy,
    output logic word_idx,
    output logic fill_en
);
    import sdram_bank_pkg::*;

    localparam int CW = $clog2(BURST_LEN) + 1;

    logic [CW-1:0] cnt_q;
    logic [CW-1:0] cnt_cur; // Index of the word on the bus now
    logic          busy_q;

    assign fill_en  = data_dst | busy_q;
    assign cnt_cur  = data_dst ? '0 : cnt_q;
    assign word_idx = cnt_cur[0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (data_rdy) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (fill_en) begin
            busy_q <= 1'b1;
            cnt_q  <= cnt_cur + 1'b1;
        end
    end

    a_rdy_at_last: assert property (
        @(posedge clk) disable iff (!arst_n)
        fill_en |-> (data_rdy == (cnt_cur == CW'(BURST_LEN - 1)))
    );

    a_rdy_in_burst: assert property (
        @(posedge clk) disable iff (!arst_n) data_rdy |-> fill_en
    );

endmodule

// ==== design/gfx_rom_bank.sv ====
// Graphics ROM bank: tile map, character and scroll slots sharing one
// SDRAM bank through a round-robin arbiter, plus the header parser.
module gfx_rom_bank (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          header_wr,
    input  logic [4:0]                    header_addr,
    input  logic [7:0]                    header_data,
    output logic [7:0]                    game_id,
    output logic                          dec_type,
    output logic                          dec_en,
    output logic                          mcu_en,
    input  logic                          map_cs,
    input  logic [mem_map_pkg::MAP_AW-1:0]  map_addr,
    output logic [15:0]                   map_data,
    output logic                          map_ok,
    input  logic                          char_cs,
    input  logic [mem_map_pkg::CHAR_AW-1:0] char_addr,
    output logic [31:0]                   char_data,
    output logic                          char_ok,
    input  logic                          scr_cs,
    input  logic [mem_map_pkg::SCR_AW-1:0]  scr_addr,
    output logic [31:0]                   scr_data,
    output logic                          scr_ok,
    output logic                          sdram_req,
    output sdram_bank_pkg::bank_addr_t    sdram_addr,
    input  logic                          sdram_ack,
    input  logic                          data_dst,
    input  logic                          data_rdy,
    input  sdram_bank_pkg::sdram_word_t   data_read
);
    import mem_map_pkg::*;
    import sdram_bank_pkg::*;

    localparam int N_SLOTS = 3; // 0 map, 1 char, 2 scroll

    bank_addr_t         slot_addr [N_SLOTS];
    logic [N_SLOTS-1:0] miss;
    logic [N_SLOTS-1:0] grant;
    logic               word_idx;
    logic               fill_en;

    // Map items are one word, char and scroll items two
    assign slot_addr[0] = MAP_OFFSET + bank_addr_t'(map_addr);
    assign slot_addr[1] = CHAR_OFFSET + bank_addr_t'({char_addr, 1'b0});
    assign slot_addr[2] = SCR_OFFSET + bank_addr_t'({scr_addr, 1'b0});

    game_header i_header (
        .clk         (clk),
        .arst_n      (arst_n),
        .header_wr   (header_wr),
        .header_addr (header_addr),
        .header_data (header_data),
        .game_id     (game_id),
        .dec_type    (dec_type),
        .dec_en      (dec_en),
        .mcu_en      (mcu_en)
    );

    rom_slot_cache #(.AW(MAP_AW), .data_t(logic [15:0])) i_map_slot (
        .clk       (clk),
        .arst_n    (arst_n),
        .cs        (map_cs),
        .addr      (map_addr),
        .data      (map_data),
        .ok        (map_ok),
        .miss      (miss[0]),
        .fill_word (data_read),
        .fill_idx  (word_idx),
        .fill_en   (fill_en & grant[0]),
        .fill_done (data_rdy & grant[0])
    );

    rom_slot_cache #(.AW(CHAR_AW), .data_t(logic [31:0])) i_char_slot (
        .clk       (clk),
        .arst_n    (arst_n),
        .cs        (char_cs),
        .addr      (char_addr),
        .data      (char_data),
        .ok        (char_ok),
        .miss      (miss[1]),
        .fill_word (data_read),
        .fill_idx  (word_idx),
        .fill_en   (fill_en & grant[1]),
        .fill_done (data_rdy & grant[1])
    );

    rom_slot_cache #(.AW(SCR_AW), .data_t(logic [31:0])) i_scr_slot (
        .clk       (clk),
        .arst_n    (arst_n),
        .cs        (scr_cs),
        .addr      (scr_addr),
        .data      (scr_data),
        .ok        (scr_ok),
        .miss      (miss[2]),
        .fill_word (data_read),
        .fill_idx  (word_idx),
        .fill_en   (fill_en & grant[2]),
        .fill_done (data_rdy & grant[2])
    );

    slot_arbiter #(.N_SLOTS(N_SLOTS)) i_arbiter (
        .clk        (clk),
        .arst_n     (arst_n),
        .miss       (miss),
        .slot_addr  (slot_addr),
        .sdram_req  (sdram_req),
        .sdram_addr (sdram_addr),
        .sdram_ack  (sdram_ack),
        .data_rdy   (data_rdy),
        .grant      (grant)
    );

    burst_counter i_burst (
        .clk      (clk),
        .arst_n   (arst_n),
        .data_dst (data_dst),
        .data_rdy (data_rdy),
        .word_idx (word_idx),
        .fill_en  (fill_en)
    );

endmodule

// ==== dv/sdram_bank_model.sv ====
// Behavioral SDRAM bank for the graphics ROM testbench. Acks each read
// after a random delay and returns a burst whose words follow a fixed
// rule on the bank address.
module sdram_bank_model (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        sdram_req,
    input  sdram_bank_pkg::bank_addr_t  sdram_addr,
    output logic                        sdram_ack,
    output logic                        data_dst,
    output logic                        data_rdy,
    output sdram_bank_pkg::sdram_word_t data_read
);
    import sdram_bank_pkg::*;

    function automatic sdram_word_t word_at(input bank_addr_t a);
        return a[15:0] ^ 16'h5a3c;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    initial begin
        bank_addr_t  addr;
        int unsigned delay;
        sdram_ack = 1'b0;
        data_dst  = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            next_cycle();
            if (arst_n && sdram_req) begin
                addr  = sdram_addr;
                delay = $urandom_range(5, 0); // Back-pressure on the arbiter
                repeat (delay) next_cycle();
                sdram_ack = 1'b1;
                next_cycle();
                sdram_ack = 1'b0;
                for (int w = 0; w < BURST_LEN; w++) begin
                    data_dst  = (w == 0);
                    data_rdy  = (w == BURST_LEN - 1);
                    data_read = word_at(addr + bank_addr_t'(w));
                    next_cycle();
                end
                data_dst  = 1'b0;
                data_rdy  = 1'b0;
                data_read = '0;
            end
        end
    end

endmodule

// ==== dv/gfx_rom_bank_tb.sv ====
// Testbench for the graphics ROM bank. Drives the header and the three
// slots against the SDRAM bank model; concurrent assertions check data,
// hold behavior, arbitration, reset state and the header outputs.
module gfx_rom_bank_tb;
    import mem_map_pkg::*;
    import sdram_bank_pkg::*;

    localparam int N_ROUNDS = 6;
    localparam int N_ACCESS = N_ROUNDS * 7;        // Six single accesses and one shared
    localparam int LIMIT    = 200 * N_ACCESS + 200; // Reset and header writes on top

    logic               clk;
    logic               arst_n;
    logic               header_wr;
    logic [4:0]         header_addr;
    logic [7:0]         header_data;
    logic [7:0]         game_id;
    logic               dec_type, dec_en, mcu_en;
    logic               map_cs, map_ok;
    logic [MAP_AW-1:0]  map_addr;
    logic [15:0]        map_data;
    logic               char_cs, char_ok;
    logic [CHAR_AW-1:0] char_addr;
    logic [31:0]        char_data;
    logic               scr_cs, scr_ok;
    logic [SCR_AW-1:0]  scr_addr;
    logic [31:0]        scr_data;
    logic               sdram_req, sdram_ack, data_dst, data_rdy;
    bank_addr_t         sdram_addr;
    sdram_word_t        data_read;

    logic [7:0]  hdr_byte [32]; // Last byte written at each header position
    logic        dec_exp_d;
    logic [2:0]  cs_vec;
    logic [2:0]  ok_vec;
    int unsigned wait_bursts [3]; // Bursts seen while a slot waits

    assign cs_vec = {scr_cs, char_cs, map_cs};
    assign ok_vec = {scr_ok, char_ok, map_ok};

    gfx_rom_bank i_dut (.*);
    sdram_bank_model i_sdram (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic sdram_word_t word_at(input bank_addr_t a);
        return a[15:0] ^ 16'h5a3c;
    endfunction

    // Two-word item, second word high
    function automatic logic [31:0] pair_at(input bank_addr_t base);
        return {word_at(base + 1'b1), word_at(base)};
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "Stopped at the first failed check");
    endtask

    task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
        stop_on_error($sformatf("** Error at %0t: %s expected %h, got %h", $time, name, exp, act));
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_header(input logic [4:0] a, input logic [7:0] d);
        header_wr   = 1'b1;
        header_addr = a;
        header_data = d;
        next_cycle();
    endtask

    // Presents the selected slots until all of them answer, then releases
    task automatic access(input logic [2:0] sel, input logic [31:0] a);
        {scr_cs, char_cs, map_cs} = sel;
        map_addr  = MAP_AW'(a);
        char_addr = CHAR_AW'(a >> 15);
        scr_addr  = SCR_AW'(a >> 11);
        next_cycle();
        while ((ok_vec & sel) != sel) next_cycle();
        repeat (3) next_cycle(); // Held address keeps ok
        {scr_cs, char_cs, map_cs} = 3'b000;
        next_cycle();
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_exp_d <= 1'b0;
            for (int i = 0; i < 32; i++) hdr_byte[i] <= '0;
            for (int s = 0; s < 3; s++) wait_bursts[s] <= 0;
        end else begin
            if (header_wr) hdr_byte[header_addr] <= header_data;
            dec_exp_d <= |hdr_byte[HDR_DEC][1:0]; // Decoder enable lags one more cycle
            for (int s = 0; s < 3; s++) begin
                if (!cs_vec[s] || ok_vec[s]) wait_bursts[s] <= 0;
                else if (data_rdy) wait_bursts[s] <= wait_bursts[s] + 1;
            end
        end
    end

    a_reset_idle: assert property (@(posedge clk) (!arst_n || $rose(arst_n)) |->
        (!sdram_req && ok_vec == 3'b000 && !dec_en && !mcu_en && game_id == '0))
        else stop_on_error("Outputs were not idle during or right after reset");
    a_map_data: assert property (@(posedge clk) disable iff (!arst_n)
        map_ok |-> map_data == word_at(MAP_OFFSET + bank_addr_t'(map_addr)))
        else value_error("map_data", word_at(MAP_OFFSET + bank_addr_t'($sampled(map_addr))),
            $sampled(map_data));
    a_char_data: assert property (@(posedge clk) disable iff (!arst_n)
        char_ok |-> char_data == pair_at(CHAR_OFFSET + bank_addr_t'(char_addr) * 2))
        else value_error("char_data", pair_at(CHAR_OFFSET + bank_addr_t'($sampled(char_addr)) * 2),
            $sampled(char_data));
    a_scr_data: assert property (@(posedge clk) disable iff (!arst_n)
        scr_ok |-> scr_data == pair_at(SCR_OFFSET + bank_addr_t'(scr_addr) * 2))
        else value_error("scr_data", pair_at(SCR_OFFSET + bank_addr_t'($sampled(scr_addr)) * 2),
            $sampled(scr_data));
    a_map_hold: assert property (@(posedge clk) disable iff (!arst_n)
        map_ok && map_cs && $stable(map_addr) |=> map_ok && $stable(map_data))
        else stop_on_error("Map slot lost ok or changed data on a held address");
    a_char_hold: assert property (@(posedge clk) disable iff (!arst_n)
        char_ok && char_cs && $stable(char_addr) |=> char_ok && $stable(char_data))
        else stop_on_error("Char slot lost ok or changed data on a held address");
    a_scr_hold: assert property (@(posedge clk) disable iff (!arst_n)
        scr_ok && scr_cs && $stable(scr_addr) |=> scr_ok && $stable(scr_data))
        else stop_on_error("Scroll slot lost ok or changed data on a held address");
    a_addr_hold: assert property (@(posedge clk) disable iff (!arst_n)
        sdram_req && !sdram_ack |=> $stable(sdram_addr))
        else stop_on_error("sdram_addr changed while the request waited for ack");
    a_no_starve: assert property (@(posedge clk) disable iff (!arst_n)
        wait_bursts[0] <= 3 && wait_bursts[1] <= 3 && wait_bursts[2] <= 3)
        else stop_on_error("A slot waited more than three bursts for its data");
    a_game_id: assert property (@(posedge clk) disable iff (!arst_n)
        game_id == hdr_byte[HDR_GAME_ID])
        else value_error("game_id", $sampled(hdr_byte[HDR_GAME_ID]), $sampled(game_id));
    a_mcu_en: assert property (@(posedge clk) disable iff (!arst_n)
        mcu_en == hdr_byte[HDR_MCU][0])
        else value_error("mcu_en", $sampled(hdr_byte[HDR_MCU][0]), $sampled(mcu_en));
    a_dec_type: assert property (@(posedge clk) disable iff (!arst_n)
        dec_type == hdr_byte[HDR_DEC][1])
        else value_error("dec_type", $sampled(hdr_byte[HDR_DEC][1]), $sampled(dec_type));
    a_dec_en: assert property (@(posedge clk) disable iff (!arst_n) dec_en == dec_exp_d)
        else value_error("dec_en", $sampled(dec_exp_d), $sampled(dec_en));

    initial begin
        logic [31:0] a;
        void'($urandom(32'h089388f0));
        arst_n      = 1'b1;
        header_wr   = 1'b0;
        header_addr = '0;
        header_data = '0;
        {scr_cs, char_cs, map_cs} = 3'b000;
        map_addr    = '0;
        char_addr   = '0;
        scr_addr    = '0;
        #1 arst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1 arst_n = 1'b1;
        for (int i = 0; i < 64; i++) write_header(5'(i), 8'($urandom)); // Each byte twice
        header_wr = 1'b0;
        repeat (2) next_cycle();
        for (int r = 0; r < N_ROUNDS; r++) begin
            a = $urandom;
            for (int s = 0; s < 3; s++) begin
                access(3'b001 << s, a);
                access(3'b001 << s, a); // Repeat of the same item hits the slot
            end
            access(3'b111, $urandom); // All three miss at once
        end
        $display("Everything OK");
        $finish;
    end

    initial begin
        repeat (LIMIT) @(posedge clk);
        stop_on_error($sformatf("Timeout: tests not finished after %0d cycles", LIMIT));
    end

endmodule

// ==== sources.f ====
design/mem_map_pkg.sv
design/sdram_bank_pkg.sv
design/game_header.sv
design/rom_slot_cache.sv
design/slot_arbiter.sv
design/burst_counter.sv
design/gfx_rom_bank.sv
dv/sdram_bank_model.sv
dv/gfx_rom_bank_tb.sv
